//--- hw/token_pkg.sv
////////////////////////////////////////////////////////////////////////////
// token parser shared types
// slice, decoded token and command structs, plus sizing constants
////////////////////////////////////////////////////////////////////////////
package token_pkg;

	localparam int SLICE_BYTES = 16;  // bytes per slice
	localparam int POS_W       = 5;   // byte position or count inside a slice
	localparam int ADDR_W      = 16;  // output-stream byte address
	localparam int OFFSET_W    = 16;  // copy offset
	localparam int FIFO_DEPTH  = 16;  // entries per command FIFO
	localparam int FIFO_MARGIN = 4;   // free entries left when near-full rises

	// token tag, bits 1:0 of the first token byte
	typedef enum logic [1:0] {
		TAG_LIT   = 2'b00,
		TAG_COPY1 = 2'b01,
		TAG_COPY2 = 2'b10,
		TAG_RSVD  = 2'b11
	} tag_e;

	// byte 0 sits in the top byte of data, so shifting left walks forward
	typedef struct packed {
		logic [8*SLICE_BYTES-1:0] data;
		logic [SLICE_BYTES-1:0]   token_pos;  // bit 15 marks byte 0
		logic [ADDR_W-1:0]        out_addr;   // address of the first output byte
		logic                     start_lit;  // slice opens inside literal content
	} slice_t;

	typedef struct packed {
		tag_e                kind;
		logic [1:0]          hdr_len;  // 1 to 3 bytes
		logic [15:0]         out_len;  // full output length minus one
		logic [OFFSET_W-1:0] offset;
	} tok_info_t;

	// literal bytes in this slice, first byte in lane 0 (top byte)
	typedef struct packed {
		logic [8*SLICE_BYTES-1:0] data;
		logic [POS_W-2:0]         len_m1;
		logic [ADDR_W-1:0]        addr;
	} lit_cmd_t;

	typedef struct packed {
		logic [ADDR_W-1:0]   addr;
		logic [OFFSET_W-1:0] offset;
		logic [6:0]          len_m1;
	} copy_cmd_t;

endpackage

//--- hw/lead_zero_count.sv
////////////////////////////////////////////////////////////////////////////
// 16-bit leading-zero counter
// two levels of 4-bit priority encoders, msb counted first
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module lead_zero_count (
	input  logic [15:0] bits_i,
	output logic        any_o,    // low when no bit is set
	output logic [3:0]  count_o
);

	logic [3:0] nib_any;      // bit 3 is the top nibble
	logic [1:0] nib_cnt [4];
	logic [1:0] sel;          // 0 selects the top nibble

	// leading zeros of one nibble, 3 when it is empty
	function automatic logic [1:0] penc4(input logic [3:0] x);
		logic [1:0] z;
		casez (x)
			4'b1???: z = 2'd0;
			4'b01??: z = 2'd1;
			4'b001?: z = 2'd2;
			default: z = 2'd3;
		endcase
		return z;
	endfunction

	for (genvar i = 0; i < 4; i++) begin : g_nib
		assign nib_any[i] = |bits_i[4*i+3 -: 4];
		assign nib_cnt[i] = penc4(bits_i[4*i+3 -: 4]);
	end

	assign any_o = |nib_any;
	assign sel   = penc4(nib_any);

	// nibble index runs the other way from sel
	assign count_o = {sel, nib_cnt[2'd3 - sel]};

endmodule

//--- hw/token_decode.sv
////////////////////////////////////////////////////////////////////////////
// token classifier
// turns the tag byte and the two bytes after it into kind, header size,
// output length and copy offset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module token_decode (
	input  logic [23:0]          bytes_i,  // token byte in 23:16
	output token_pkg::tok_info_t info_o
);
	import token_pkg::*;

	logic [7:0] b0;
	logic [7:0] b1;
	logic [7:0] b2;
	logic [5:0] f;     // upper six bits of the tag byte
	tag_e       tag;

	assign b0  = bytes_i[23:16];
	assign b1  = bytes_i[15:8];
	assign b2  = bytes_i[7:0];
	assign f   = b0[7:2];
	assign tag = tag_e'(b0[1:0]);

	always_comb begin
		info_o.kind    = tag;
		info_o.hdr_len = 2'd1;
		info_o.out_len = '0;
		info_o.offset  = '0;

		case (tag)
			TAG_LIT: begin
				if (f == 6'd60) begin
					// one length byte follows
					info_o.hdr_len = 2'd2;
					info_o.out_len = 16'(b1);
				end else if (f == 6'd61) begin
					// two length bytes, little-endian
					info_o.hdr_len = 2'd3;
					info_o.out_len = {b2, b1};
				end else begin
					info_o.out_len = 16'(f);  // length lives in the tag byte
				end
			end

			TAG_COPY1: begin
				info_o.hdr_len = 2'd2;
				info_o.out_len = 16'(b0[4:2]) + 16'd3;  // length 4..11
				info_o.offset  = OFFSET_W'({b0[7:5], b1});
			end

			TAG_COPY2: begin
				info_o.hdr_len = 2'd3;
				info_o.out_len = 16'(f);
				info_o.offset  = {b2, b1};
			end

			default: begin
				// reserved tag keeps the defaults, single header byte
				info_o.hdr_len = 2'd1;
			end
		endcase
	end

endmodule

//--- hw/slice_tokenizer.sv
////////////////////////////////////////////////////////////////////////////
// slice tokenizer
// takes one slice at a time and steps through its token starts, one token
// per cycle, issuing literal and copy commands
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module slice_tokenizer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  token_pkg::slice_t    slice_i,
	input  logic                 slice_valid_i,
	output logic                 slice_ready_o,
	output token_pkg::lit_cmd_t  lit_cmd_o,
	output logic                 lit_push_o,
	output token_pkg::copy_cmd_t copy_cmd_o,
	output logic                 copy_push_o,
	input  logic                 lit_near_full_i,
	input  logic                 copy_near_full_i
);
	import token_pkg::*;

	typedef enum logic [1:0] {
		S_WAIT,   // waiting for a slice
		S_CONT,   // bytes ahead of the first token start
		S_TOKEN   // token at byte 0
	} state_e;

	state_e           state_q;
	slice_t           buf_q;       // shifted as tokens are consumed
	logic [POS_W-1:0] left_q;      // valid bytes from byte 0 on
	logic             ready_q;
	logic             pause_q;     // registered near-full of either FIFO
	lit_cmd_t         lit_q;
	logic             lit_push_q;
	copy_cmd_t        copy_q;
	logic             copy_push_q;

	logic [15:0]       lzc_bits;
	logic              lzc_any;
	logic [3:0]        lzc_count;
	tok_info_t         info;
	logic [POS_W-1:0]  step;
	logic [POS_W-1:0]  cont_len;
	logic [POS_W-1:0]  cont_m1;
	logic [POS_W-1:0]  avail;        // literal bytes after the header
	logic [POS_W-1:0]  avail_m1;
	logic              lit_room;
	logic [POS_W-2:0]  tok_lit_m1;
	logic [ADDR_W-1:0] tok_next_addr;

	// in the token state byte 0 is the current token, so mask its own start
	assign lzc_bits = (state_q == S_CONT) ? buf_q.token_pos
	                                      : {1'b0, buf_q.token_pos[14:0]};

	lead_zero_count u_lzc (
		.bits_i  (lzc_bits),
		.any_o   (lzc_any),
		.count_o (lzc_count)
	);

	token_decode u_dec (
		.bytes_i (buf_q.data[8*SLICE_BYTES-1 -: 24]),
		.info_o  (info)
	);

	assign step     = POS_W'(lzc_count);
	assign cont_len = lzc_any ? step : left_q;  // whole slice when no start
	assign cont_m1  = cont_len - 1'b1;

	assign avail    = left_q - POS_W'(info.hdr_len);
	assign avail_m1 = avail - 1'b1;
	assign lit_room = left_q > POS_W'(info.hdr_len);

	// literal is cut at the slice end
	assign tok_lit_m1 = (info.out_len < 16'(avail)) ? info.out_len[POS_W-2:0]
	                                                : avail_m1[POS_W-2:0];

	assign tok_next_addr = (info.kind == TAG_RSVD) ? buf_q.out_addr
	                                               : buf_q.out_addr + info.out_len + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= S_WAIT;
			ready_q     <= 1'b0;
			pause_q     <= 1'b0;
			lit_push_q  <= 1'b0;
			copy_push_q <= 1'b0;
		end else begin
			pause_q     <= lit_near_full_i | copy_near_full_i;
			lit_push_q  <= 1'b0;
			copy_push_q <= 1'b0;

			case (state_q)
				S_WAIT: begin
					ready_q <= 1'b1;
					if (slice_valid_i && ready_q) begin
						buf_q   <= slice_i;
						left_q  <= POS_W'(SLICE_BYTES);
						ready_q <= 1'b0;
						// bytes ahead of the first start go through S_CONT
						if (slice_i.start_lit || !slice_i.token_pos[15]) begin
							state_q <= S_CONT;
						end else begin
							state_q <= S_TOKEN;
						end
					end
				end

				S_CONT: begin
					if (!pause_q) begin
						if (buf_q.start_lit && cont_len != '0) begin
							lit_q.data   <= buf_q.data;
							lit_q.len_m1 <= cont_m1[POS_W-2:0];
							lit_q.addr   <= buf_q.out_addr;
							lit_push_q   <= 1'b1;
						end
						buf_q.data      <= buf_q.data << (8 * step);
						buf_q.token_pos <= buf_q.token_pos << step;
						buf_q.out_addr  <= buf_q.out_addr + ADDR_W'(cont_len);
						left_q          <= left_q - cont_len;
						if (lzc_any) begin
							state_q <= S_TOKEN;
						end else begin
							state_q <= S_WAIT;
							ready_q <= 1'b1;
						end
					end
				end

				S_TOKEN: begin
					if (!pause_q) begin
						case (info.kind)
							TAG_LIT: begin
								if (lit_room) begin  // header may end the slice
									lit_q.data   <= buf_q.data << (8 * info.hdr_len);
									lit_q.len_m1 <= tok_lit_m1;
									lit_q.addr   <= buf_q.out_addr;
									lit_push_q   <= 1'b1;
								end
							end
							TAG_COPY1, TAG_COPY2: begin
								copy_q.addr   <= buf_q.out_addr;
								copy_q.offset <= info.offset;
								copy_q.len_m1 <= info.out_len[6:0];
								copy_push_q   <= 1'b1;
							end
							default: begin
								// reserved tag, nothing to issue
								copy_push_q <= 1'b0;
							end
						endcase
						buf_q.data      <= buf_q.data << (8 * step);
						buf_q.token_pos <= buf_q.token_pos << step;
						buf_q.out_addr  <= tok_next_addr;
						left_q          <= left_q - step;
						if (!lzc_any) begin  // last token start of the slice
							state_q <= S_WAIT;
							ready_q <= 1'b1;
						end
					end
				end

				default: state_q <= S_WAIT;
			endcase
		end
	end

	assign slice_ready_o = ready_q;
	assign lit_cmd_o     = lit_q;
	assign lit_push_o    = lit_push_q;
	assign copy_cmd_o    = copy_q;
	assign copy_push_o   = copy_push_q;

	// near-full shuts off pushes two cycles later via the registered pause
	a_no_push_paused: assert property (@(posedge clk) disable iff (!rst_n)
		(lit_near_full_i || copy_near_full_i) |-> ##2 !(lit_push_o || copy_push_o))
		else $error("command pushed during a near-full pause");

	a_no_rsvd_tag: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == S_TOKEN && !pause_q) |-> (info.kind != TAG_RSVD))
		else $error("reserved tag 11 in token stream");

	a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q != S_WAIT) |-> !slice_ready_o)
		else $error("slice_ready_o high while a slice is in work");

endmodule

//--- hw/cmd_fifo.sv
////////////////////////////////////////////////////////////////////////////
// command FIFO
// circular buffer with a show-ahead output register and valid/ready pop
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cmd_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push_i,
	input  payload_t push_data_i,
	output logic     near_full_o,
	output payload_t pop_data_o,
	output logic     pop_valid_o,
	input  logic     pop_ready_i
);
	import token_pkg::*;

	payload_t                      mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(FIFO_DEPTH):0]   count_q;     // entries in mem, not the output reg
	payload_t                      out_q;
	logic                          out_valid_q;
	logic                          mem_empty;
	logic                          mem_full;
	logic                          push_ok;
	logic                          rd_en;

	assign mem_empty = (count_q == '0);
	assign mem_full  = (count_q == FIFO_DEPTH);
	assign push_ok   = push_i && !mem_full;

	// refill the output reg when it is empty or being taken
	assign rd_en = !mem_empty && (!out_valid_q || pop_ready_i);

	assign near_full_o = (count_q >= FIFO_DEPTH - FIFO_MARGIN);

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr_q] <= push_data_i;
		end
		if (rd_en) begin
			out_q <= mem[rd_ptr_q];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			out_valid_q <= 1'b0;
		end else begin
			if (push_ok) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (rd_en) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_ok, rd_en})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // none or both
			endcase
			if (rd_en) begin
				out_valid_q <= 1'b1;
			end else if (pop_ready_i) begin
				out_valid_q <= 1'b0;  // taken with nothing behind it
			end
		end
	end

	assign pop_data_o  = out_q;
	assign pop_valid_o = out_valid_q;

	// near-full margin must absorb the pushes still in flight upstream
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push_i |-> !mem_full)
		else $error("push into a full command FIFO");

	a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(pop_valid_o && !pop_ready_i) |=> (pop_valid_o && $stable(pop_data_o)))
		else $error("FIFO output changed while stalled");

endmodule

//--- hw/token_parser_top.sv
////////////////////////////////////////////////////////////////////////////
// token parser top
// tokenizer feeding one literal and one copy command FIFO
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module token_parser_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  token_pkg::slice_t    slice_i,
	input  logic                 slice_valid_i,
	output logic                 slice_ready_o,
	output token_pkg::lit_cmd_t  lit_o,
	output logic                 lit_valid_o,
	input  logic                 lit_ready_i,
	output token_pkg::copy_cmd_t copy_o,
	output logic                 copy_valid_o,
	input  logic                 copy_ready_i
);
	import token_pkg::*;

	lit_cmd_t  lit_cmd;
	logic      lit_push;
	logic      lit_near_full;
	copy_cmd_t copy_cmd;
	logic      copy_push;
	logic      copy_near_full;

	slice_tokenizer u_tok (
		.clk              (clk),
		.rst_n            (rst_n),
		.slice_i          (slice_i),
		.slice_valid_i    (slice_valid_i),
		.slice_ready_o    (slice_ready_o),
		.lit_cmd_o        (lit_cmd),
		.lit_push_o       (lit_push),
		.copy_cmd_o       (copy_cmd),
		.copy_push_o      (copy_push),
		.lit_near_full_i  (lit_near_full),
		.copy_near_full_i (copy_near_full)
	);

	cmd_fifo #(.payload_t(lit_cmd_t)) u_lit_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (lit_push),
		.push_data_i (lit_cmd),
		.near_full_o (lit_near_full),
		.pop_data_o  (lit_o),
		.pop_valid_o (lit_valid_o),
		.pop_ready_i (lit_ready_i)
	);

	cmd_fifo #(.payload_t(copy_cmd_t)) u_copy_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (copy_push),
		.push_data_i (copy_cmd),
		.near_full_o (copy_near_full),
		.pop_data_o  (copy_o),
		.pop_valid_o (copy_valid_o),
		.pop_ready_i (copy_ready_i)
	);

endmodule

//--- tests/tb_token_parser.sv
////////////////////////////////////////////////////////////////////////////
// token parser testbench
// builds token streams into slices, predicts the commands of each channel
// and checks every output handshake against the predicted order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_token_parser;
	import token_pkg::*;

	logic      clk;
	logic      rst_n;
	slice_t    slice;
	logic      slice_valid;
	logic      slice_ready;
	lit_cmd_t  lit;
	logic      lit_valid;
	logic      lit_ready;
	copy_cmd_t copy;
	logic      copy_valid;
	logic      copy_ready;

	logic [31:0] lfsr;
	int          errors;
	int          lit_seen;
	int          copy_seen;
	logic        rand_ready;    // random ready pattern on both channels
	logic        copy_hold;     // copy channel held not-ready
	logic        expect_busy;
	lit_cmd_t    lit_exp [$];
	copy_cmd_t   copy_exp [$];
	lit_cmd_t    lit_head;
	copy_cmd_t   copy_head;
	logic        lit_have;
	logic        copy_have;

	// slice under construction
	logic [7:0]  sb [16];
	logic [15:0] spos;
	int          pos;
	logic [15:0] s_addr;
	logic        s_start;
	logic [15:0] tok_addr;      // output address of the next token
	logic [15:0] carry_addr;    // literal content still owed to later slices
	int          carry_left;
	int          pend_pos [$];
	lit_cmd_t    pend [$];

	token_parser_top dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.slice_i       (slice),
		.slice_valid_i (slice_valid),
		.slice_ready_o (slice_ready),
		.lit_o         (lit),
		.lit_valid_o   (lit_valid),
		.lit_ready_i   (lit_ready),
		.copy_o        (copy),
		.copy_valid_o  (copy_valid),
		.copy_ready_i  (copy_ready)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout: %s", what);
		$display("Errors found");
		$finish;
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			errors++;
			$display("FAIL t=%0t %s expected %b got %b", $time, name, want, got);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished, errors so far %0d", name, errors);
	endtask

	// ready patterns and the queue heads the assertions compare against
	always @(negedge clk) begin
		int r;
		if (rand_ready) begin
			take_bits(1, r);
			lit_ready = r[0];
			take_bits(1, r);
			copy_ready = r[0] && !copy_hold;
		end else begin
			lit_ready  = 1'b1;
			copy_ready = !copy_hold;
		end
		lit_have  = lit_exp.size() > 0;
		lit_head  = lit_have ? lit_exp[0] : '0;
		copy_have = copy_exp.size() > 0;
		copy_head = copy_have ? copy_exp[0] : '0;
	end

	always @(posedge clk) begin
		if (rst_n && lit_valid && lit_ready && lit_exp.size() > 0) begin
			void'(lit_exp.pop_front());
			lit_seen++;
		end
		if (rst_n && copy_valid && copy_ready && copy_exp.size() > 0) begin
			void'(copy_exp.pop_front());
			copy_seen++;
		end
	end

	a_lit_match: assert property (@(posedge clk) disable iff (!rst_n)
		(lit_valid && lit_ready) |-> (lit_have && lit == lit_head))
		else begin
			errors++;
			$display("FAIL t=%0t lit_o expected %h got %h (expected none if queue empty: %b)",
				$time, $sampled(lit_head), $sampled(lit), !$sampled(lit_have));
		end

	a_copy_match: assert property (@(posedge clk) disable iff (!rst_n)
		(copy_valid && copy_ready) |-> (copy_have && copy == copy_head))
		else begin
			errors++;
			$display("FAIL t=%0t copy_o expected %h got %h (expected none if queue empty: %b)",
				$time, $sampled(copy_head), $sampled(copy), !$sampled(copy_have));
		end

	a_busy_stall: assert property (@(posedge clk) disable iff (!rst_n)
		expect_busy |-> !slice_ready)
		else begin
			errors++;
			$display("FAIL t=%0t slice_ready_o expected 0 got 1", $time);
		end

	task automatic add_pending(input int start, input int len_m1, input logic [15:0] addr);
		lit_cmd_t c;
		c        = '0;
		c.len_m1 = 4'(len_m1);
		c.addr   = addr;
		pend_pos.push_back(start);
		pend.push_back(c);
	endtask

	task automatic begin_slice();
		int v;
		int n;
		spos = '0;
		pos  = 0;
		for (int i = 0; i < 16; i++) begin
			take_bits(8, v);
			sb[i] = 8'(v);  // literal content and filler
		end
		s_start = carry_left > 0;
		s_addr  = s_start ? carry_addr : tok_addr;
		if (s_start) begin
			n = (carry_left < 16) ? carry_left : 16;
			add_pending(0, n - 1, carry_addr);
			carry_addr = carry_addr + 16'(n);
			carry_left = carry_left - n;
			pos        = n;
		end
	endtask

	// form 0 keeps the length in the tag byte, 1 and 2 add length bytes
	task automatic add_lit(input int len, input int form);
		int hdr;
		int avail;
		int take;
		hdr = form + 1;
		spos[15 - pos] = 1'b1;
		if (form == 0) begin
			sb[pos] = {6'(len - 1), 2'b00};
		end else begin
			sb[pos] = (form == 1) ? 8'hf0 : 8'hf4;
			sb[pos + 1] = 8'(len - 1);
		end
		if (form == 2) begin
			sb[pos + 2] = 8'((len - 1) >> 8);
		end
		avail = 16 - pos - hdr;
		take  = (len < avail) ? len : avail;
		if (take > 0) begin
			add_pending(pos + hdr, take - 1, tok_addr);
		end
		if (len > take) begin
			carry_left = len - take;
			carry_addr = tok_addr + 16'(take);
		end
		pos      = pos + hdr + take;
		tok_addr = tok_addr + 16'(len);
	endtask

	task automatic add_copy(input int kind, input int len, input int off);
		copy_cmd_t c;
		spos[15 - pos] = 1'b1;
		if (kind == 1) begin
			sb[pos]     = {3'(off >> 8), 3'(len - 4), 2'b01};
			sb[pos + 1] = 8'(off);
		end else begin
			sb[pos]     = {6'(len - 1), 2'b10};
			sb[pos + 1] = 8'(off);
			sb[pos + 2] = 8'(off >> 8);
		end
		c.addr   = tok_addr;
		c.offset = 16'(off);
		c.len_m1 = 7'(len - 1);
		copy_exp.push_back(c);
		tok_addr = tok_addr + 16'(len);
		pos      = pos + kind + 1;
	endtask

	task automatic fill_slice(input logic copy_only);
		int k;
		int l;
		int o;
		int r;
		while (pos < 16) begin
			r = 16 - pos;
			take_bits(2, k);
			take_bits(3, l);
			take_bits(16, o);
			if (copy_only) begin
				k = (r == 3) ? 3 : ((r >= 2) ? 2 : 0);
			end
			if (k >= 2 && r >= k) begin
				add_copy(k - 1, (k == 2) ? l + 4 : 8 * l + 1, (k == 2) ? (o & 'h7ff) : o);
			end else begin
				add_lit(l + 1, 0);  // may run past the slice end
			end
		end
	endtask

	task automatic send_slice();
		logic [127:0] d;
		lit_cmd_t     c;
		int           p;
		int           t;
		for (int i = 0; i < 16; i++) begin
			d[127 - 8 * i -: 8] = sb[i];
		end
		while (pend.size() > 0) begin
			c      = pend.pop_front();
			p      = pend_pos.pop_front();
			c.data = d << (8 * p);  // zero fill past the slice end
			lit_exp.push_back(c);
		end
		@(negedge clk);
		slice.data      = d;
		slice.token_pos = spos;
		slice.out_addr  = s_addr;
		slice.start_lit = s_start;
		slice_valid     = 1'b1;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!slice_ready && t < 300);
		if (!slice_ready) begin
			fail_timeout("slice_ready_o never rose to take a slice");
		end
		@(negedge clk);
		slice_valid = 1'b0;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while ((lit_exp.size() > 0 || copy_exp.size() > 0) && t < 3000) begin
			@(negedge clk);
			t++;
		end
		if (lit_exp.size() > 0 || copy_exp.size() > 0) begin
			fail_timeout("expected commands did not all arrive on the outputs");
		end
		repeat (4) @(negedge clk);
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		slice       = '0;
		slice_valid = 1'b0;
		lit_ready   = 1'b1;
		copy_ready  = 1'b1;
		rand_ready  = 1'b0;
		copy_hold   = 1'b0;
		expect_busy = 1'b0;
		errors      = 0;
		lit_seen    = 0;
		copy_seen   = 0;
		lfsr        = 32'hf41a_d444;
		tok_addr    = 16'h0100;
		carry_addr  = '0;
		carry_left  = 0;

		repeat (8) begin
			@(negedge clk);
			check_bit("slice_ready_o", slice_ready, 1'b0);
			check_bit("lit_valid_o", lit_valid, 1'b0);
			check_bit("copy_valid_o", copy_valid, 1'b0);
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("slice_ready_o", slice_ready, 1'b1);
		check_bit("lit_valid_o", lit_valid, 1'b0);
		check_bit("copy_valid_o", copy_valid, 1'b0);
		end_test("reset");

		begin_slice();
		add_lit(3, 0);
		add_lit(5, 0);
		add_lit(8, 1);  // cut at the slice end, 4 bytes carried
		send_slice();
		drain();
		end_test("literals");

		begin_slice();
		add_copy(1, 7, 'h2a5);
		add_lit(2, 2);
		add_copy(2, 33, 'h1234);
		add_copy(1, 4, 9);
		send_slice();
		drain();
		end_test("copies");

		begin_slice();
		add_copy(2, 64, 'hbeef);
		add_lit(40, 1);
		send_slice();
		begin_slice();  // no token starts at all
		send_slice();
		begin_slice();
		add_copy(1, 11, 'h7ff);
		send_slice();
		drain();
		end_test("continuation");

		rand_ready = 1'b1;
		repeat (12) begin
			begin_slice();
			fill_slice(1'b0);
			send_slice();
		end
		while (carry_left > 0) begin
			begin_slice();
			fill_slice(1'b1);
			send_slice();
		end
		drain();
		end_test("random ready");

		// 16 copies against a blocked channel push the FIFO to near-full
		copy_hold = 1'b1;
		repeat (2) begin
			begin_slice();
			fill_slice(1'b1);
			send_slice();
		end
		repeat (40) @(negedge clk);
		expect_busy = 1'b1;
		repeat (20) @(negedge clk);
		expect_busy = 1'b0;
		copy_hold   = 1'b0;
		drain();
		end_test("copy stall");

		$display("literals %0d, copies %0d, errors %0d", lit_seen, copy_seen, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- token_parser.f
hw/token_pkg.sv
hw/lead_zero_count.sv
hw/token_decode.sv
hw/slice_tokenizer.sv
hw/cmd_fifo.sv
hw/token_parser_top.sv
tests/tb_token_parser.sv

//--- Makefile
# Verilator build and run for the token parser testbench

VERILATOR ?= verilator
TOP       ?= tb_token_parser
FLIST     ?= token_parser.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
